// File: egress_pkg.sv
////////////////////////////////////////////////////////////
// Egress router sizes, beat structs and demux state type
////////////////////////////////////////////////////////////

`default_nettype none

package egress_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes

    localparam int NUM_PORTS     = 4;
    localparam int PORT_W        = 2;
    localparam int DATA_W        = 32;
    localparam int BUF_DEPTH     = 32;
    localparam int MAX_PKT_WORDS = 8;
    localparam int CNT_W         = 16;

    // Buffer pointer and occupancy widths
    localparam int PTR_W         = $clog2(BUF_DEPTH);
    localparam int OCC_W         = $clog2(BUF_DEPTH + 1);

    // Highest occupancy that still leaves room for a whole packet
    localparam int ROOM_LIMIT    = BUF_DEPTH - MAX_PKT_WORDS;

    ////////////////////////////////////////////////////////////
    // Types

    typedef logic [PORT_W-1:0]    port_idx_t;
    typedef logic [NUM_PORTS-1:0] port_mask_t;
    typedef logic [CNT_W-1:0]     cnt_t;

    // Ingress word, tagged with its destination
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
        port_idx_t         port;
    } ingress_beat_t;

    // Word as held and sent by an egress port
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } port_beat_t;

    typedef enum logic [1:0] {
        ST_HEAD,
        ST_PASS,
        ST_DROP
    } demux_state_t;

endpackage

`default_nettype wire

// File: egress_demux.sv
////////////////////////////////////////////////////////////
// Ingress demux: per-packet port choice and drop decision
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module egress_demux (
    input  logic                      clk_ifc,
    input  logic                      rst_n,
    input  egress_pkg::ingress_beat_t in_beat,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  egress_pkg::port_mask_t    port_enable,
    input  egress_pkg::port_mask_t    buf_room,
    output egress_pkg::port_mask_t    wr_en,
    output egress_pkg::port_beat_t    wr_beat,
    output egress_pkg::port_mask_t    drop_pulse
);
    import egress_pkg::*;

    demux_state_t state;
    port_idx_t    cur_port;
    logic         accept;
    logic         head_ok;
    port_mask_t   head_sel;
    port_mask_t   pass_sel;

    assign accept   = in_valid & in_ready;
    assign head_sel = port_mask_t'(1) << in_beat.port;
    assign pass_sel = port_mask_t'(1) << cur_port;

    // Target must be enabled and able to take a full-size packet
    assign head_ok  = port_enable[in_beat.port] & buf_room[in_beat.port];

    ////////////////////////////////////////////////////////////
    // Packet FSM and write strobes

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            state      <= ST_HEAD;
            cur_port   <= '0;
            in_ready   <= 1'b0;
            wr_en      <= '0;
            drop_pulse <= '0;
        end else begin
            // Never back-pressures, unwanted packets are absorbed
            in_ready   <= 1'b1;
            wr_en      <= '0;
            drop_pulse <= '0;
            if (accept) begin
                unique case (state)
                    ST_HEAD: begin
                        cur_port <= in_beat.port;
                        if (head_ok) begin
                            wr_en <= head_sel;
                            if (!in_beat.last) begin
                                state <= ST_PASS;
                            end
                        end else begin
                            drop_pulse <= head_sel;
                            if (!in_beat.last) begin
                                state <= ST_DROP;
                            end
                        end
                    end
                    ST_PASS: begin
                        // Stays on the port chosen at the head word
                        wr_en <= pass_sel;
                        if (in_beat.last) begin
                            state <= ST_HEAD;
                        end
                    end
                    ST_DROP: begin
                        if (in_beat.last) begin
                            state <= ST_HEAD;
                        end
                    end
                    default: begin
                        state <= ST_HEAD;
                    end
                endcase
            end
        end
    end

    // Word toward the buffers, qualified by wr_en
    always_ff @(posedge clk_ifc) begin
        if (accept) begin
            wr_beat <= '{data: in_beat.data, last: in_beat.last};
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks

    a_no_write_in_drop: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        (state == ST_DROP) |-> (wr_en == '0)
    );

    a_wr_en_onehot0: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        $onehot0(wr_en)
    );

endmodule

`default_nettype wire

// File: egress_port_buffer.sv
////////////////////////////////////////////////////////////
// Per-port word FIFO with room flag and output stream
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module egress_port_buffer (
    input  logic                   clk_ifc,
    input  logic                   rst_n,
    input  logic                   wr_en,
    input  egress_pkg::port_beat_t wr_beat,
    output logic                   room,
    output logic                   out_valid,
    input  logic                   out_ready,
    output egress_pkg::port_beat_t out_beat
);
    import egress_pkg::*;

    port_beat_t       mem [BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // Words held in total, memory plus output register
    logic [OCC_W-1:0] occ;
    logic             pop;
    logic             mem_avail;
    logic             load;

    assign pop       = out_valid & out_ready;
    assign mem_avail = (occ != OCC_W'(out_valid));
    assign load      = mem_avail & (~out_valid | pop);

    // Word on wr_en is counted too, it lands next edge
    assign room = (occ + OCC_W'(wr_en)) <= OCC_W'(ROOM_LIMIT);

    ////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk_ifc) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (load) begin
            out_beat <= mem[rd_ptr];
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointers, occupancy and output valid

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occ       <= '0;
            out_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (load) begin
                rd_ptr    <= rd_ptr + 1'b1;
                out_valid <= 1'b1;
            end else if (pop) begin
                out_valid <= 1'b0;
            end
            occ <= occ + OCC_W'(wr_en) - OCC_W'(pop);
        end
    end

    // Room check in the demux must keep writes off a full buffer
    a_no_write_full: assert property (
        @(posedge clk_ifc) disable iff (!rst_n)
        wr_en |-> (occ < OCC_W'(BUF_DEPTH))
    );

endmodule

`default_nettype wire

// File: egress_frame_counters.sv
////////////////////////////////////////////////////////////
// Per-port egress frame and drop counters with clear
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module egress_frame_counters (
    input  logic                   clk_ifc,
    input  logic                   rst_n,
    input  egress_pkg::port_mask_t out_valid,
    input  egress_pkg::port_mask_t out_ready,
    input  egress_pkg::port_mask_t out_last,
    input  egress_pkg::port_mask_t drop_pulse,
    input  egress_pkg::port_mask_t cnt_clear,
    output egress_pkg::cnt_t       frame_cnt [egress_pkg::NUM_PORTS],
    output egress_pkg::cnt_t       drop_cnt  [egress_pkg::NUM_PORTS]
);
    import egress_pkg::*;

    // A frame completes on the handshake carrying last
    port_mask_t frame_done;

    assign frame_done = out_valid & out_ready & out_last;

    always_ff @(posedge clk_ifc) begin
        if (!rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                frame_cnt[p] <= '0;
                drop_cnt[p]  <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                // Clear wins over a same-cycle event
                if (cnt_clear[p]) begin
                    frame_cnt[p] <= '0;
                    drop_cnt[p]  <= '0;
                end else begin
                    if (frame_done[p]) begin
                        frame_cnt[p] <= frame_cnt[p] + 1'b1;
                    end
                    if (drop_pulse[p]) begin
                        drop_cnt[p] <= drop_cnt[p] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: egress_router_top.sv
////////////////////////////////////////////////////////////
// Egress router top: demux, four port buffers, counters
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module egress_router_top (
    input  logic                      clk_ifc,
    input  logic                      rst_n,
    // Ingress stream
    input  egress_pkg::ingress_beat_t in_beat,
    input  logic                      in_valid,
    output logic                      in_ready,
    // Control
    input  egress_pkg::port_mask_t    port_enable,
    input  egress_pkg::port_mask_t    cnt_clear,
    // Egress streams
    input  egress_pkg::port_mask_t    out_ready,
    output egress_pkg::port_mask_t    out_valid,
    output egress_pkg::port_beat_t    out_beat [egress_pkg::NUM_PORTS],
    // Status
    output egress_pkg::port_mask_t    drop_pulse,
    output egress_pkg::cnt_t          frame_cnt [egress_pkg::NUM_PORTS],
    output egress_pkg::cnt_t          drop_cnt  [egress_pkg::NUM_PORTS]
);
    import egress_pkg::*;

    port_mask_t wr_en;
    port_beat_t wr_beat;
    port_mask_t buf_room;
    port_mask_t out_last;

    ////////////////////////////////////////////////////////////
    // Ingress demux

    egress_demux u_demux (
        .clk_ifc     (clk_ifc),
        .rst_n       (rst_n),
        .in_beat     (in_beat),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .port_enable (port_enable),
        .buf_room    (buf_room),
        .wr_en       (wr_en),
        .wr_beat     (wr_beat),
        .drop_pulse  (drop_pulse)
    );

    ////////////////////////////////////////////////////////////
    // Port buffers

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        egress_port_buffer u_buf (
            .clk_ifc   (clk_ifc),
            .rst_n     (rst_n),
            .wr_en     (wr_en[p]),
            .wr_beat   (wr_beat),
            .room      (buf_room[p]),
            .out_valid (out_valid[p]),
            .out_ready (out_ready[p]),
            .out_beat  (out_beat[p])
        );

        // Last bits gathered into a mask for the counters
        assign out_last[p] = out_beat[p].last;
    end

    ////////////////////////////////////////////////////////////
    // Counters

    egress_frame_counters u_counters (
        .clk_ifc    (clk_ifc),
        .rst_n      (rst_n),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_last   (out_last),
        .drop_pulse (drop_pulse),
        .cnt_clear  (cnt_clear),
        .frame_cnt  (frame_cnt),
        .drop_cnt   (drop_cnt)
    );

endmodule

`default_nettype wire

// File: egress_router_checker.sv
////////////////////////////////////////////////////////////
// Egress router checker: packet, drop and counter compare
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module egress_router_checker (
    input  logic                      clk_ifc,
    input  logic                      rst_n,
    input  egress_pkg::ingress_beat_t in_beat,
    input  logic                      in_valid,
    input  logic                      in_ready,
    input  logic                      pred_first,
    input  logic                      pred_accept,
    input  egress_pkg::port_mask_t    cnt_clear,
    input  egress_pkg::port_mask_t    out_ready,
    input  egress_pkg::port_mask_t    out_valid,
    input  egress_pkg::port_beat_t    out_beat  [egress_pkg::NUM_PORTS],
    input  egress_pkg::port_mask_t    drop_pulse,
    input  egress_pkg::cnt_t          frame_cnt [egress_pkg::NUM_PORTS],
    input  egress_pkg::cnt_t          drop_cnt  [egress_pkg::NUM_PORTS],
    input  logic                      test_end,
    input  logic [7:0]                test_id,
    output logic                      drained,
    output int                        error_count,
    output int                        check_count
);
    import egress_pkg::*;

    // Expected words per port in egress order
    port_beat_t exp_q [NUM_PORTS][$];
    cnt_t       frame_model [NUM_PORTS];
    cnt_t       drop_model  [NUM_PORTS];
    port_mask_t drop_expect;
    // Predicted last word leaving a port at this edge
    port_mask_t frame_event;
    port_beat_t head;
    int         errors         = 0;
    int         checks         = 0;
    int         errors_at_mark = 0;
    int         reset_edges    = 0;
    int         run_edges      = 0;
    int         pending;

    assign error_count = errors;
    assign check_count = checks;

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_test(input string label);
        int fresh;
        fresh = errors - errors_at_mark;
        $display("Test %s finished at %0t with %0d errors", label, $time, fresh);
        errors_at_mark = errors;
    endtask

    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'd1:    return "routing";
            8'd2:    return "port enable";
            8'd3:    return "buffer full";
            8'd4:    return "counters";
            8'd5:    return "counter clear";
            default: return $sformatf("number %0d", id);
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Sampled at each rising edge, before the DUT registers move

    always @(posedge clk_ifc) begin
        if (!rst_n) begin
            // Register values are unknown until the first reset edge
            if (reset_edges > 0) begin
                compare_value("in_ready", 1'b0, in_ready);
                compare_value("out_valid", '0, out_valid);
                compare_value("drop_pulse", '0, drop_pulse);
                for (int p = 0; p < NUM_PORTS; p++) begin
                    compare_value($sformatf("frame_cnt[%0d]", p), '0, frame_cnt[p]);
                    compare_value($sformatf("drop_cnt[%0d]", p), '0, drop_cnt[p]);
                end
            end
            reset_edges++;
            run_edges   = 0;
            drop_expect = '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                frame_model[p] = '0;
                drop_model[p]  = '0;
            end
            drained <= 1'b1;
        end else begin
            run_edges++;
            // Ready comes up one cycle after reset and stays up
            compare_value("in_ready", (run_edges > 1), in_ready);
            if (run_edges == 2) begin
                report_test("reset");
            end
            compare_value("drop_pulse", drop_expect, drop_pulse);
            for (int p = 0; p < NUM_PORTS; p++) begin
                compare_value($sformatf("frame_cnt[%0d]", p), frame_model[p], frame_cnt[p]);
                compare_value($sformatf("drop_cnt[%0d]", p), drop_model[p], drop_cnt[p]);
            end

            // Egress words against the predicted packets
            for (int p = 0; p < NUM_PORTS; p++) begin
                frame_event[p] = 1'b0;
                if (out_valid[p] && exp_q[p].size() == 0) begin
                    checks++;
                    errors++;
                    $display("Port %0d raised out_valid at %0t with no packet pending",
                             p, $time);
                end else if (out_valid[p] && out_ready[p]) begin
                    head = exp_q[p].pop_front();
                    compare_value($sformatf("out_beat[%0d].data", p),
                                  head.data, out_beat[p].data);
                    compare_value($sformatf("out_beat[%0d].last", p),
                                  head.last, out_beat[p].last);
                    frame_event[p] = head.last;
                end
            end

            // Clear takes priority in the counter model
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (cnt_clear[p]) begin
                    frame_model[p] = '0;
                    drop_model[p]  = '0;
                end else begin
                    if (frame_event[p]) begin
                        frame_model[p] = frame_model[p] + 16'd1;
                    end
                    if (drop_expect[p]) begin
                        drop_model[p] = drop_model[p] + 16'd1;
                    end
                end
            end

            // A dropped head word taken now gives its drop pulse next edge
            drop_expect = '0;
            if (in_valid && in_ready) begin
                if (pred_accept) begin
                    head.data = in_beat.data;
                    head.last = in_beat.last;
                    exp_q[in_beat.port].push_back(head);
                end else if (pred_first) begin
                    drop_expect[in_beat.port] = 1'b1;
                end
            end

            if (test_end) begin
                report_test(test_name(test_id));
            end

            pending = 0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                pending += exp_q[p].size();
            end
            drained <= (pending == 0);
        end
    end

endmodule

`default_nettype wire

// File: egress_router_tb.sv
////////////////////////////////////////////////////////////
// Egress router testbench: clock, reset, vector-driven
// packet stimulus, free space model and watchdog
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module egress_router_tb;
    import egress_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 8;
    localparam int MAX_CMDS     = 64;
    localparam int FIELDS       = 6;
    localparam int SLACK_CYCLES = 200;

    localparam logic [7:0] CMD_SEND     = 8'h01;
    localparam logic [7:0] CMD_CLEAR    = 8'h02;
    localparam logic [7:0] CMD_TEST_END = 8'h03;
    localparam logic [7:0] CMD_STOP     = 8'hff;

    logic          clk_ifc;
    logic          rst_n;
    ingress_beat_t in_beat;
    logic          in_valid;
    logic          in_ready;
    port_mask_t    port_enable;
    port_mask_t    cnt_clear;
    port_mask_t    out_ready;
    port_mask_t    out_valid;
    port_beat_t    out_beat  [NUM_PORTS];
    port_mask_t    drop_pulse;
    cnt_t          frame_cnt [NUM_PORTS];
    cnt_t          drop_cnt  [NUM_PORTS];

    // Predictions and test markers toward the checker
    logic          pred_first;
    logic          pred_accept;
    logic          test_end;
    logic [7:0]    test_id;
    logic          drained;
    int            error_count;
    int            check_count;

    logic [7:0]    vec_mem [MAX_CMDS*FIELDS];
    logic [31:0]   lfsr_state;
    int            reserved_words [NUM_PORTS];
    int            egress_words   [NUM_PORTS];
    int            cycle_limit;
    logic          limit_ready;

    egress_router_top uut (
        .clk_ifc     (clk_ifc),
        .rst_n       (rst_n),
        .in_beat     (in_beat),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .port_enable (port_enable),
        .cnt_clear   (cnt_clear),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_beat    (out_beat),
        .drop_pulse  (drop_pulse),
        .frame_cnt   (frame_cnt),
        .drop_cnt    (drop_cnt)
    );

    egress_router_checker u_checker (
        .clk_ifc     (clk_ifc),
        .rst_n       (rst_n),
        .in_beat     (in_beat),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .pred_first  (pred_first),
        .pred_accept (pred_accept),
        .cnt_clear   (cnt_clear),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_beat    (out_beat),
        .drop_pulse  (drop_pulse),
        .frame_cnt   (frame_cnt),
        .drop_cnt    (drop_cnt),
        .test_end    (test_end),
        .test_id     (test_id),
        .drained     (drained),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial begin
        clk_ifc = 1'b0;
        forever #(CLK_PERIOD / 2) clk_ifc = ~clk_ifc;
    end

    // Words handed back by each port feed the free space model
    always @(posedge clk_ifc) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!rst_n) begin
                egress_words[p] <= 0;
            end else if (out_valid[p] && out_ready[p]) begin
                egress_words[p] <= egress_words[p] + 1;
            end
        end
    end

    initial begin : watchdog
        wait (limit_ready);
        repeat (cycle_limit) @(posedge clk_ifc);
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("TB FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic random_word(output logic [31:0] word);
        for (int b = 0; b < DATA_W; b++) begin
            word[b]    = lfsr_state[0];
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_ifc);
        #DRIVE_DELAY;
    endtask

    task automatic wait_handshake();
        @(posedge clk_ifc);
        while (!in_ready) @(posedge clk_ifc);
        #DRIVE_DELAY;
    endtask

    task automatic wait_drained();
        while (!drained) next_cycle();
    endtask

    task automatic load_vectors();
        int idx;
        int words;
        int gaps;
        for (int i = 0; i < MAX_CMDS * FIELDS; i++) begin
            vec_mem[i] = CMD_STOP;
        end
        $readmemh("egress_vectors.mem", vec_mem);
        idx   = 0;
        words = 0;
        gaps  = 0;
        while (idx < MAX_CMDS && vec_mem[idx*FIELDS] != CMD_STOP) begin
            if (vec_mem[idx*FIELDS] == CMD_SEND) begin
                words += int'(vec_mem[idx*FIELDS+4]);
            end
            gaps += int'(vec_mem[idx*FIELDS+5]);
            idx++;
        end
        // Ingress words and gap cycles plus a margin for reset and draining
        cycle_limit = words + gaps + SLACK_CYCLES;
        limit_ready = 1'b1;
        $display("Loaded %0d commands with %0d words, watchdog at %0d cycles",
                 idx, words, cycle_limit);
    endtask

    task automatic send_packet(input port_idx_t port, input int len, input int gap);
        logic [31:0] word;
        logic        accept;
        int          free_space;
        free_space = BUF_DEPTH - reserved_words[port] + egress_words[port];
        accept     = port_enable[port] && (free_space >= MAX_PKT_WORDS);
        if (accept) begin
            reserved_words[port] += len;
        end
        for (int i = 0; i < len; i++) begin
            random_word(word);
            in_beat     = '{data: word, last: (i == len - 1), port: port};
            in_valid    = 1'b1;
            pred_first  = (i == 0);
            pred_accept = accept;
            wait_handshake();
        end
        in_valid    = 1'b0;
        pred_first  = 1'b0;
        pred_accept = 1'b0;
        repeat (gap) next_cycle();
    endtask

    task automatic run_command(input int idx);
        logic [7:0] cmd;
        port_idx_t  port;
        int         base;
        int         len;
        int         gap;
        base        = idx * FIELDS;
        cmd         = vec_mem[base];
        port_enable = port_mask_t'(vec_mem[base+1]);
        out_ready   = port_mask_t'(vec_mem[base+2]);
        port        = port_idx_t'(vec_mem[base+3]);
        len         = int'(vec_mem[base+4]);
        gap         = int'(vec_mem[base+5]);
        case (cmd)
            CMD_SEND: begin
                send_packet(port, len, gap);
            end
            CMD_CLEAR: begin
                cnt_clear       = '0;
                cnt_clear[port] = 1'b1;
                next_cycle();
                cnt_clear = '0;
                repeat (gap) next_cycle();
            end
            CMD_TEST_END: begin
                // Counters are read two cycles after the last egress word
                wait_drained();
                repeat (2) next_cycle();
                test_id  = vec_mem[base+3];
                test_end = 1'b1;
                next_cycle();
                test_end = 1'b0;
                repeat (gap) next_cycle();
            end
            default: begin
                repeat (gap) next_cycle();
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin : main_flow
        int idx;
        rst_n       = 1'b0;
        in_beat     = '0;
        in_valid    = 1'b0;
        port_enable = '0;
        cnt_clear   = '0;
        out_ready   = '0;
        pred_first  = 1'b0;
        pred_accept = 1'b0;
        test_end    = 1'b0;
        test_id     = '0;
        limit_ready = 1'b0;
        lfsr_state  = 32'h5e1f_42d9;
        for (int p = 0; p < NUM_PORTS; p++) begin
            reserved_words[p] = 0;
        end
        load_vectors();

        repeat (RESET_CYCLES) @(posedge clk_ifc);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        idx = 0;
        while (idx < MAX_CMDS && vec_mem[idx*FIELDS] != CMD_STOP) begin
            run_command(idx);
            idx++;
        end
        wait_drained();
        repeat (2) next_cycle();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: egress_vectors.mem
// Egress router commands, one per line: cmd enable_mask ready_mask port length gap
// cmd 00 idle, 01 send, 02 clear port counters, 03 end of test (port = test id), ff stop
01 0f 0f 00 04 00
01 0f 0f 01 08 01
01 0f 0f 02 01 00
01 0f 0f 03 05 02
01 0f 0f 00 08 00
01 0f 0f 01 02 00
01 0f 0f 02 07 03
01 0f 0f 03 03 00
03 0f 0f 01 00 02
// Ports 1 and 3 disabled
01 05 0f 01 03 00
01 05 0f 00 02 01
01 05 0f 03 08 00
01 05 0f 02 04 00
01 05 0f 03 01 02
03 0f 0f 02 00 02
// Port 0 stalled until its buffer runs short of room
01 0f 0e 00 08 00
01 0f 0e 00 08 00
01 0f 0e 01 03 00
01 0f 0e 00 08 00
01 0f 0e 00 03 00
01 0f 0e 00 08 01
01 0f 0e 00 01 00
00 0f 0f 00 00 28
01 0f 0f 00 08 00
03 0f 0f 03 00 02
// Mixed traffic for the counters, port 2 disabled
01 0b 0f 02 02 00
01 0b 0f 03 06 00
01 0b 0f 01 01 00
01 0b 0f 02 05 01
03 0f 0f 04 00 02
02 0f 0f 02 00 01
01 0f 0f 02 02 00
02 0f 0f 00 00 00
03 0f 0f 05 00 02
ff 00 00 00 00 00

// File: egress_router_top.f
egress_pkg.sv
egress_demux.sv
egress_port_buffer.sv
egress_frame_counters.sv
egress_router_top.sv
egress_router_checker.sv
egress_router_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the egress router testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=egress_router_sim

verilator --binary --timing --assert -Wno-fatal \
    -f egress_router_top.f \
    --top-module egress_router_tb \
    -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "Result: failure reported in $LOG"
    exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
    echo "Result: no verdict found in $LOG"
    exit 1
fi
echo "Result: pass"
exit 0
